//--- source/axi_mux_pkg.sv
/*
 * Shared widths, AXI write channel structs, port request/response bundles
 * and the W ordering FSM state type for the write multiplexer
 */
package axi_mux_pkg;

  localparam int unsigned NumPorts     = 2;  // Slave ports merged onto the master
  localparam int unsigned PortIdxWidth = 1;  // Bits of a port index
  localparam int unsigned SlvIdWidth   = 4;
  localparam int unsigned MstIdWidth   = SlvIdWidth + PortIdxWidth;  // Index sits above slave ID
  localparam int unsigned AddrWidth    = 16;
  localparam int unsigned DataWidth    = 16;
  localparam int unsigned FifoDepth    = 4;  // Outstanding bursts awaiting W data

  typedef logic [PortIdxWidth-1:0] port_idx_t;

  typedef struct packed {
    logic [SlvIdWidth-1:0] id;
    logic [AddrWidth-1:0]  addr;
    logic [7:0]            len;   // Beats minus one
  } slv_aw_chan_t;

  typedef struct packed {
    logic [MstIdWidth-1:0] id;    // {port index, slave ID}
    logic [AddrWidth-1:0]  addr;
    logic [7:0]            len;
  } mst_aw_chan_t;

  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 last;
  } w_chan_t;

  typedef struct packed {
    logic [SlvIdWidth-1:0] id;
    logic [1:0]            resp;
  } slv_b_chan_t;

  typedef struct packed {
    logic [MstIdWidth-1:0] id;
    logic [1:0]            resp;
  } mst_b_chan_t;

  // Port bundles, requests flow toward the slave side of the bus
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
  } slv_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    slv_b_chan_t b;
    logic        b_valid;
  } slv_resp_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
  } mst_req_t;

  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    mst_b_chan_t b;
    logic        b_valid;
  } mst_resp_t;

  typedef enum logic {
    W_IDLE,   // Waiting for a granted AW in the route FIFO
    W_BURST   // Forwarding beats of the head port
  } w_state_e;

endpackage

//--- source/aw_rr_arbiter.sv
/*
 * Round-robin AW arbiter with grant lock under master stall
 * Widens the AW ID with the granted port index and reports each grant
 */
`timescale 1ns/100ps

module aw_rr_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  axi_mux_pkg::slv_aw_chan_t [axi_mux_pkg::NumPorts-1:0] slv_aw_i,
  input  logic                      [axi_mux_pkg::NumPorts-1:0] slv_aw_valid_i,
  output logic                      [axi_mux_pkg::NumPorts-1:0] slv_aw_ready_o,
  output axi_mux_pkg::mst_aw_chan_t                             mst_aw_o,
  output logic                                                  mst_aw_valid_o,
  input  logic                                                  mst_aw_ready_i,
  input  logic                                                  fifo_full_i,
  output logic                                                  aw_push_o,
  output axi_mux_pkg::port_idx_t                                aw_port_o
);
  import axi_mux_pkg::*;

  port_idx_t prio_q;      // First port to look at
  logic      lock_q;      // Grant presented but not yet taken
  port_idx_t lock_idx_q;
  port_idx_t pick_idx;
  logic      pick_vld;
  port_idx_t gnt_idx;
  logic      hs;

  // Scan from the priority pointer onward, circularly
  always_comb begin
    port_idx_t cand;
    pick_idx = prio_q;
    pick_vld = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = port_idx_t'((prio_q + i) % NumPorts);
      if (!pick_vld && slv_aw_valid_i[cand]) begin
        pick_idx = cand;
        pick_vld = 1'b1;
      end
    end
  end

  assign gnt_idx        = lock_q ? lock_idx_q : pick_idx;  // Hold a stalled grant
  assign mst_aw_valid_o = (lock_q || pick_vld) && !fifo_full_i;
  assign hs             = mst_aw_valid_o && mst_aw_ready_i;

  assign mst_aw_o.id   = {gnt_idx, slv_aw_i[gnt_idx].id};  // Port index above slave ID
  assign mst_aw_o.addr = slv_aw_i[gnt_idx].addr;
  assign mst_aw_o.len  = slv_aw_i[gnt_idx].len;

  always_comb begin
    slv_aw_ready_o          = '0;
    slv_aw_ready_o[gnt_idx] = hs;  // Only the granted port sees ready
  end

  assign aw_push_o = hs;       // Record order for the W path
  assign aw_port_o = gnt_idx;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;  // Port 0 first after reset
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (hs) begin
        prio_q <= port_idx_t'((gnt_idx + 1) % NumPorts);  // Next port in circular order
        lock_q <= 1'b0;
      end else if (mst_aw_valid_o) begin
        lock_q     <= 1'b1;     // Master stalled, keep this grant
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

//--- source/w_route_fifo.sv
/*
 * FIFO of granted port indexes
 * Read/write pointers and an occupancy count over FifoDepth entries
 */
`timescale 1ns/100ps

module w_route_fifo (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  axi_mux_pkg::port_idx_t push_port_i,
  input  logic                   pop_i,
  output axi_mux_pkg::port_idx_t head_port_o,
  output logic                   empty_o,
  output logic                   full_o
);
  import axi_mux_pkg::*;

  port_idx_t                        mem_q [FifoDepth];  // Port order storage
  logic [$clog2(FifoDepth)-1:0]     wr_ptr_q;
  logic [$clog2(FifoDepth)-1:0]     rd_ptr_q;
  logic [$clog2(FifoDepth+1)-1:0]   count_q;            // Entries held
  logic                             do_push;
  logic                             do_pop;

  assign full_o      = (count_q == FifoDepth);
  assign empty_o     = (count_q == 0);
  assign head_port_o = mem_q[rd_ptr_q];
  assign do_push     = push_i && !full_o;   // Arbiter blocks AW when full anyway
  assign do_pop      = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_port_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == FifoDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == FifoDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end  // Push with pop keeps the count
    end
  end

endmodule

//--- source/w_order_fsm.sv
/*
 * W ordering FSM
 * Steers bursts from the port at the FIFO head, pops on the last beat
 */
`timescale 1ns/100ps

module w_order_fsm (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  axi_mux_pkg::w_chan_t [axi_mux_pkg::NumPorts-1:0] slv_w_i,
  input  logic                 [axi_mux_pkg::NumPorts-1:0] slv_w_valid_i,
  output logic                 [axi_mux_pkg::NumPorts-1:0] slv_w_ready_o,
  output axi_mux_pkg::w_chan_t                             mst_w_o,
  output logic                                             mst_w_valid_o,
  input  logic                                             mst_w_ready_i,
  input  axi_mux_pkg::port_idx_t                           head_port_i,
  input  logic                                             fifo_empty_i,
  output logic                                             pop_o
);
  import axi_mux_pkg::*;

  w_state_e state_q;
  w_state_e state_d;
  logic     in_burst;
  logic     beat_hs;

  assign in_burst = (state_q == W_BURST);

  // Head port's W passes straight through while in a burst
  assign mst_w_o       = slv_w_i[head_port_i];
  assign mst_w_valid_o = in_burst && slv_w_valid_i[head_port_i];
  assign beat_hs       = mst_w_valid_o && mst_w_ready_i;
  assign pop_o         = beat_hs && mst_w_o.last;  // Burst done, drop its FIFO entry

  always_comb begin
    slv_w_ready_o              = '0;
    slv_w_ready_o[head_port_i] = in_burst && mst_w_ready_i;  // Other ports stay stalled
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE: begin
        if (!fifo_empty_i) state_d = W_BURST;  // A granted AW waits for data
      end
      W_BURST: begin
        if (pop_o) state_d = W_IDLE;
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- source/b_resp_router.sv
/*
 * One-entry B response register
 * Routes by the ID upper bits and strips them toward the slave port
 */
`timescale 1ns/100ps

module b_resp_router (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  axi_mux_pkg::mst_b_chan_t                             mst_b_i,
  input  logic                                                 mst_b_valid_i,
  output logic                                                 mst_b_ready_o,
  output axi_mux_pkg::slv_b_chan_t [axi_mux_pkg::NumPorts-1:0] slv_b_o,
  output logic                     [axi_mux_pkg::NumPorts-1:0] slv_b_valid_o,
  input  logic                     [axi_mux_pkg::NumPorts-1:0] slv_b_ready_i
);
  import axi_mux_pkg::*;

  mst_b_chan_t b_q;       // Held response
  logic        full_q;
  port_idx_t   dst_port;  // Upper ID bits select the port
  logic        taken;
  logic        load;

  assign dst_port      = b_q.id[MstIdWidth-1 -: PortIdxWidth];
  assign taken         = full_q && slv_b_ready_i[dst_port];
  assign mst_b_ready_o = !full_q || taken;  // Refill in the cycle the entry drains
  assign load          = mst_b_valid_i && mst_b_ready_o;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_slv_b
    assign slv_b_o[i].id    = b_q.id[SlvIdWidth-1:0];  // Index bits stripped
    assign slv_b_o[i].resp  = b_q.resp;
    assign slv_b_valid_o[i] = full_q && (dst_port == port_idx_t'(i));
  end

  always_ff @(posedge clk_i) begin
    if (load) b_q <= mst_b_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (taken) begin
      full_q <= 1'b0;
    end
  end

endmodule

//--- source/axi_write_mux.sv
/*
 * Write-only AXI multiplexer top level
 * AW arbiter, W route FIFO, W ordering FSM and B router
 */
`timescale 1ns/100ps

module axi_write_mux (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  axi_mux_pkg::slv_req_t  [axi_mux_pkg::NumPorts-1:0] slv_reqs_i,
  output axi_mux_pkg::slv_resp_t [axi_mux_pkg::NumPorts-1:0] slv_resps_o,
  output axi_mux_pkg::mst_req_t                              mst_req_o,
  input  axi_mux_pkg::mst_resp_t                             mst_resp_i
);
  import axi_mux_pkg::*;

  slv_aw_chan_t [NumPorts-1:0] slv_aw;
  logic         [NumPorts-1:0] slv_aw_valid;
  logic         [NumPorts-1:0] slv_aw_ready;
  w_chan_t      [NumPorts-1:0] slv_w;
  logic         [NumPorts-1:0] slv_w_valid;
  logic         [NumPorts-1:0] slv_w_ready;
  slv_b_chan_t  [NumPorts-1:0] slv_b;
  logic         [NumPorts-1:0] slv_b_valid;
  logic         [NumPorts-1:0] slv_b_ready;
  logic                        aw_push;    // One per master AW handshake
  port_idx_t                   aw_port;
  logic                        fifo_full;
  logic                        fifo_empty;
  port_idx_t                   head_port;  // Port owning the current W burst
  logic                        w_pop;

  // Unpack port bundles into per-channel vectors
  for (genvar i = 0; i < NumPorts; i++) begin : gen_ports
    assign slv_aw[i]                = slv_reqs_i[i].aw;
    assign slv_aw_valid[i]          = slv_reqs_i[i].aw_valid;
    assign slv_w[i]                 = slv_reqs_i[i].w;
    assign slv_w_valid[i]           = slv_reqs_i[i].w_valid;
    assign slv_b_ready[i]           = slv_reqs_i[i].b_ready;
    assign slv_resps_o[i].aw_ready  = slv_aw_ready[i];
    assign slv_resps_o[i].w_ready   = slv_w_ready[i];
    assign slv_resps_o[i].b         = slv_b[i];
    assign slv_resps_o[i].b_valid   = slv_b_valid[i];
  end

  aw_rr_arbiter i_aw_arb (
    .clk_i, .rst_ni,
    .slv_aw_i      (slv_aw),            .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o(slv_aw_ready),      .mst_aw_o       (mst_req_o.aw),
    .mst_aw_valid_o(mst_req_o.aw_valid), .mst_aw_ready_i(mst_resp_i.aw_ready),
    .fifo_full_i   (fifo_full),         .aw_push_o      (aw_push),
    .aw_port_o     (aw_port)
  );

  w_route_fifo i_w_fifo (
    .clk_i, .rst_ni,
    .push_i     (aw_push),   .push_port_i(aw_port),    .pop_i  (w_pop),
    .head_port_o(head_port), .empty_o    (fifo_empty), .full_o (fifo_full)
  );

  w_order_fsm i_w_fsm (
    .clk_i, .rst_ni,
    .slv_w_i      (slv_w),             .slv_w_valid_i(slv_w_valid),
    .slv_w_ready_o(slv_w_ready),       .mst_w_o      (mst_req_o.w),
    .mst_w_valid_o(mst_req_o.w_valid), .mst_w_ready_i(mst_resp_i.w_ready),
    .head_port_i  (head_port),         .fifo_empty_i (fifo_empty),
    .pop_o        (w_pop)
  );

  b_resp_router i_b_router (
    .clk_i, .rst_ni,
    .mst_b_i      (mst_resp_i.b),      .mst_b_valid_i(mst_resp_i.b_valid),
    .mst_b_ready_o(mst_req_o.b_ready), .slv_b_o      (slv_b),
    .slv_b_valid_o(slv_b_valid),       .slv_b_ready_i(slv_b_ready)
  );

endmodule

//--- verif/tb_clk_gen.sv
/*
 * Testbench clock (4 ns period) and active-low reset held for 2 cycles
 */
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // Release away from the active edge
  end

endmodule

//--- verif/axi_write_mux_sva.sv
/*
 * Concurrent assertions bound to the write multiplexer top level
 * Master AW/W and slave B stability under stall
 */
`timescale 1ns/100ps

module axi_write_mux_sva (
  input logic                                               clk_i,
  input logic                                               rst_ni,
  input axi_mux_pkg::slv_req_t  [axi_mux_pkg::NumPorts-1:0] slv_reqs_i,
  input axi_mux_pkg::slv_resp_t [axi_mux_pkg::NumPorts-1:0] slv_resps_i,
  input axi_mux_pkg::mst_req_t                              mst_req_i,
  input axi_mux_pkg::mst_resp_t                             mst_resp_i
);
  import axi_mux_pkg::*;

  int assert_fails = 0;  // Failed assertions so far

  aw_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_req_i.aw_valid && !mst_resp_i.aw_ready |=> mst_req_i.aw_valid && $stable(mst_req_i.aw))
    else begin
      $error("Master AW dropped or changed while stalled");
      assert_fails++;
    end

  w_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_req_i.w_valid && !mst_resp_i.w_ready |=> mst_req_i.w_valid && $stable(mst_req_i.w))
    else begin
      $error("Master W dropped or changed while stalled");
      assert_fails++;
    end

  // A routed response waits unchanged until its port takes it
  for (genvar i = 0; i < NumPorts; i++) begin : gen_slv_b
    b_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      slv_resps_i[i].b_valid && !slv_reqs_i[i].b_ready |=>
        slv_resps_i[i].b_valid && $stable(slv_resps_i[i].b))
      else begin
        $error("Slave B dropped or changed while stalled");
        assert_fails++;
      end
  end

endmodule

bind axi_write_mux axi_write_mux_sva i_sva (
  .clk_i, .rst_ni, .slv_reqs_i, .slv_resps_i(slv_resps_o), .mst_req_i(mst_req_o), .mst_resp_i
);

//--- verif/tb_axi_write_mux.sv
/*
 * Directed testbench for the write multiplexer
 * Slave drivers, master-side model, handshake monitor, compare tasks, watchdog
 */
`timescale 1ns/100ps

module tb_axi_write_mux;
  import axi_mux_pkg::*;

  localparam int ClkPeriod  = 4;
  localparam int TotalBeats = 50;  // 3 + 4 + 4 + 32 + 5 + 2 over the six tests

  typedef w_chan_t      beat_q_t[$];
  typedef slv_aw_chan_t aw_q_t[$];

  logic                     clk;
  logic                     rst_n;
  slv_req_t  [NumPorts-1:0] slv_reqs;
  slv_resp_t [NumPorts-1:0] slv_resps;
  mst_req_t                 mst_req;
  mst_resp_t                mst_resp;
  logic [31:0]              rnd_state = 32'd51458;
  logic                     stall_en;      // Master model toggles its readies
  int                       err_cnt;
  int                       errs_at_start;
  int                       test_cnt;
  int                       test_fails;
  mst_aw_chan_t             aw_seen[$];    // Master AW handshakes in order
  w_chan_t                  w_seen[$];     // Master W handshakes in order
  slv_b_chan_t              b_seen[$];     // Slave B handshakes
  int                       b_port[$];     // Port that took each B

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  axi_write_mux dut (
    .clk_i(clk), .rst_ni(rst_n), .slv_reqs_i(slv_reqs), .slv_resps_o(slv_resps),
    .mst_req_o(mst_req), .mst_resp_i(mst_resp)
  );

  function automatic logic [31:0] xorshift();
    rnd_state ^= rnd_state << 13;
    rnd_state ^= rnd_state >> 17;
    rnd_state ^= rnd_state << 5;
    return rnd_state;
  endfunction

  function automatic beat_q_t make_beats(int n);
    beat_q_t q;
    for (int i = 0; i < n; i++) begin
      q.push_back('{data: DataWidth'(xorshift()), last: (i == n - 1)});  // Last on final beat
    end
    return q;
  endfunction

  function automatic slv_aw_chan_t rand_aw(int len);
    return '{id: SlvIdWidth'(xorshift()), addr: AddrWidth'(xorshift()), len: 8'(len)};
  endfunction

  // Port index sits above the slave ID
  function automatic mst_aw_chan_t widen(int p, slv_aw_chan_t aw);
    return '{id: MstIdWidth'((p << SlvIdWidth) | aw.id), addr: aw.addr, len: aw.len};
  endfunction

  // Monitor samples handshakes on the rising edge, before any register update
  always @(posedge clk) begin
    if (rst_n) begin
      if (mst_req.aw_valid && mst_resp.aw_ready) aw_seen.push_back(mst_req.aw);
      if (mst_req.w_valid && mst_resp.w_ready) w_seen.push_back(mst_req.w);
      for (int p = 0; p < NumPorts; p++) begin
        if (slv_resps[p].b_valid && slv_reqs[p].b_ready) begin
          b_seen.push_back(slv_resps[p].b);
          b_port.push_back(p);
        end
      end
    end
  end

  always @(negedge clk) begin  // Master side AW/W readies
    logic [31:0] r;
    r = xorshift();
    mst_resp.aw_ready = !stall_en || r[0];
    mst_resp.w_ready  = !stall_en || r[1];
  end

  task automatic send_aws(int p, aw_q_t aws);
    foreach (aws[i]) begin
      @(negedge clk);
      slv_reqs[p].aw       = aws[i];
      slv_reqs[p].aw_valid = 1'b1;  // Held high across back-to-back AWs
      @(posedge clk);
      while (!slv_resps[p].aw_ready) @(posedge clk);
    end
    @(negedge clk);
    slv_reqs[p].aw_valid = 1'b0;
  endtask

  task automatic send_w(int p, beat_q_t beats);
    foreach (beats[i]) begin
      @(negedge clk);
      slv_reqs[p].w       = beats[i];
      slv_reqs[p].w_valid = 1'b1;
      @(posedge clk);
      while (!slv_resps[p].w_ready) @(posedge clk);
    end
    @(negedge clk);
    slv_reqs[p].w_valid = 1'b0;
  endtask

  task automatic send_b(mst_b_chan_t b);
    @(negedge clk);
    mst_resp.b       = b;
    mst_resp.b_valid = 1'b1;
    @(posedge clk);
    while (!mst_req.b_ready) @(posedge clk);
    @(negedge clk);
    mst_resp.b_valid = 1'b0;
  endtask

  task automatic wait_w(int n);
    while (w_seen.size() < n) @(negedge clk);
  endtask

  task automatic wait_b(int n);
    while (b_seen.size() < n) @(negedge clk);
  endtask

  task automatic compare_mst_aw(string name, mst_aw_chan_t exp, mst_aw_chan_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: AW expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_w(string name, w_chan_t exp, w_chan_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: W expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_slv_b(string name, slv_b_chan_t exp, slv_b_chan_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: B expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check(string name, bit ok, string what);
    if (!ok) begin
      err_cnt++;
      $display("%s: %s", name, what);
    end
  endtask

  task automatic start_test();
    @(negedge clk);
    aw_seen.delete();
    w_seen.delete();
    b_seen.delete();
    b_port.delete();
    errs_at_start = err_cnt;
  endtask

  task automatic end_test(string name);
    test_cnt++;
    if (err_cnt == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      test_fails++;
      $display("%s: %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  task automatic test_single_write();
    string       name = "single_write";
    aw_q_t       aws;
    beat_q_t     beats;
    mst_b_chan_t b;
    start_test();
    aws.push_back(rand_aw(2));
    aws[0].id = 4'd5;
    beats = make_beats(3);
    fork
      send_aws(1, aws);
      send_w(1, beats);
    join
    wait_w(3);
    check(name, aw_seen.size() == 1, "master saw the wrong number of AWs");
    compare_mst_aw(name, widen(1, aws[0]), aw_seen[0]);  // Wide ID 21
    foreach (beats[i]) compare_w(name, beats[i], w_seen[i]);
    b = '{id: 5'd21, resp: 2'(xorshift())};
    send_b(b);
    wait_b(1);
    check(name, b_seen.size() == 1, "B response reached more than one port");
    check(name, b_port[0] == 1, "B response went to the wrong port");
    compare_slv_b(name, '{id: 4'd5, resp: b.resp}, b_seen[0]);
    end_test(name);
  endtask

  task automatic test_round_robin();
    string name = "round_robin";
    aw_q_t a0;
    aw_q_t a1;
    start_test();
    for (int i = 0; i < 2; i++) begin
      a0.push_back(rand_aw(0));
      a1.push_back(rand_aw(0));
    end
    fork
      send_aws(0, a0);
      send_aws(1, a1);
    join
    fork
      repeat (2) send_w(0, make_beats(1));
      repeat (2) send_w(1, make_beats(1));
    join
    check(name, aw_seen.size() == 4, "master saw the wrong number of AWs");
    for (int i = 0; i < 4; i++) begin
      compare_mst_aw(name, widen(i % 2, (i % 2) ? a1[i / 2] : a0[i / 2]), aw_seen[i]);
    end
    end_test(name);
  endtask

  task automatic test_w_ordering();
    string   name = "w_ordering";
    aw_q_t   a0;
    aw_q_t   a1;
    beat_q_t w0;
    beat_q_t w1;
    start_test();
    a0.push_back(rand_aw(1));
    a1.push_back(rand_aw(1));
    w0 = make_beats(2);
    w1 = make_beats(2);
    send_aws(1, a1);  // Port 1 granted first
    send_aws(0, a0);
    fork
      send_w(0, w0);
      begin
        repeat (3) @(negedge clk);  // Port 0 offers its W first
        send_w(1, w1);
      end
    join
    check(name, w_seen.size() == 4, "master saw the wrong number of W beats");
    for (int i = 0; i < 2; i++) begin
      compare_w(name, w1[i], w_seen[i]);
      compare_w(name, w0[i], w_seen[i + 2]);
    end
    end_test(name);
  endtask

  task automatic test_long_bursts();
    string   name = "long_bursts";
    aw_q_t   aws;
    beat_q_t beats;
    beat_q_t exp;
    start_test();
    stall_en = 1'b1;
    for (int k = 0; k < 4; k++) begin
      aws   = '{rand_aw(int'(xorshift() % 8))};  // Up to 8 beats
      beats = make_beats(aws[0].len + 1);
      foreach (beats[i]) exp.push_back(beats[i]);
      fork
        send_aws(k % 2, aws);
        send_w(k % 2, beats);
      join
    end
    stall_en = 1'b0;
    check(name, w_seen.size() == exp.size(), "beats lost or duplicated");
    foreach (exp[i]) compare_w(name, exp[i], w_seen[i]);
    end_test(name);
  endtask

  task automatic test_fifo_full();
    string name = "fifo_full";
    aw_q_t a0;
    aw_q_t a1;
    start_test();
    for (int i = 0; i < FifoDepth; i++) a0.push_back(rand_aw(0));
    a1.push_back(rand_aw(0));
    send_aws(0, a0);  // No W yet, route FIFO fills
    fork
      send_aws(1, a1);
      begin
        repeat (4) begin
          @(posedge clk);
          check(name, !slv_resps[1].aw_ready && !mst_req.aw_valid,
                "AW offered or accepted while the route FIFO was full");
        end
        repeat (FifoDepth) send_w(0, make_beats(1));
      end
    join
    send_w(1, make_beats(1));
    check(name, aw_seen.size() == FifoDepth + 1, "extra AW was never accepted");
    compare_mst_aw(name, widen(1, a1[0]), aw_seen[FifoDepth]);
    end_test(name);
  endtask

  task automatic test_b_backpressure();
    string       name = "b_backpressure";
    mst_b_chan_t ba;
    mst_b_chan_t bb;
    start_test();
    ba = '{id: MstIdWidth'(xorshift() % 16), resp: 2'(xorshift())};  // Port 0 IDs
    bb = '{id: MstIdWidth'(xorshift() % 16), resp: 2'(xorshift())};
    slv_reqs[0].b_ready = 1'b0;
    fork
      begin
        send_b(ba);
        send_b(bb);
      end
      begin
        repeat (3) @(posedge clk);
        repeat (4) begin
          @(posedge clk);
          compare_slv_b(name, '{id: SlvIdWidth'(ba.id), resp: ba.resp}, slv_resps[0].b);
          check(name, slv_resps[0].b_valid && !mst_req.b_ready,
                "held B not presented or master B not stalled");
        end
        @(negedge clk);
        slv_reqs[0].b_ready = 1'b1;
      end
    join
    wait_b(2);
    compare_slv_b(name, '{id: SlvIdWidth'(ba.id), resp: ba.resp}, b_seen[0]);
    compare_slv_b(name, '{id: SlvIdWidth'(bb.id), resp: bb.resp}, b_seen[1]);
    end_test(name);
  endtask

  initial begin
    slv_reqs = '0;
    for (int p = 0; p < NumPorts; p++) slv_reqs[p].b_ready = 1'b1;
    mst_resp      = '0;
    stall_en      = 1'b0;
    err_cnt       = 0;
    errs_at_start = 0;
    test_cnt      = 0;
    test_fails    = 0;
    @(posedge rst_n);
    test_single_write();
    test_round_robin();
    test_w_ordering();
    test_long_bursts();
    test_fifo_full();
    test_b_backpressure();
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
             test_cnt, test_fails, err_cnt, dut.i_sva.assert_fails);
    if (err_cnt == 0 && dut.i_sva.assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // 20 cycles per beat over all tests
  initial begin
    #(TotalBeats * 20 * ClkPeriod);
    $display("Watchdog expired after %0d ns, DUT stopped responding",
             TotalBeats * 20 * ClkPeriod);
    $display("Test failed");
    $finish;
  end

endmodule

//--- vlog.f
source/axi_mux_pkg.sv
source/aw_rr_arbiter.sv
source/w_route_fifo.sv
source/w_order_fsm.sv
source/b_resp_router.sv
source/axi_write_mux.sv
verif/tb_clk_gen.sv
verif/axi_write_mux_sva.sv
verif/tb_axi_write_mux.sv

//--- Bender.yml
package:
  name: axi_write_mux

sources:
  - source/axi_mux_pkg.sv
  - source/aw_rr_arbiter.sv
  - source/w_route_fifo.sv
  - source/w_order_fsm.sv
  - source/b_resp_router.sv
  - source/axi_write_mux.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/axi_write_mux_sva.sv
      - verif/tb_axi_write_mux.sv
